/* design/rv_pkg.sv */
// Encodings for the RV64 subset only (lui, auipc, jal, jalr, addi, sd, ebreak); IMEM_DEPTH must stay a power of two
package rv_pkg;

  localparam int XLEN = 64;
  localparam logic [XLEN-1:0] RESET_PC = '0;

  // Instruction store, word addressed
  localparam int IMEM_DEPTH = 256;
  localparam int IMEM_AW = $clog2(IMEM_DEPTH);

  localparam int NR_REGS = 32;

  // Major opcodes
  localparam logic [6:0] OPC_LUI = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC = 7'b0010111;
  localparam logic [6:0] OPC_JAL = 7'b1101111;
  localparam logic [6:0] OPC_JALR = 7'b1100111;
  localparam logic [6:0] OPC_OPIMM = 7'b0010011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  localparam logic [2:0] F3_ADDI = 3'b000;
  localparam logic [2:0] F3_SD = 3'b011;
  localparam logic [2:0] F3_JALR = 3'b000;

  // Immediate formats
  localparam logic [2:0] EXT_I = 3'b000;
  localparam logic [2:0] EXT_U = 3'b001;
  localparam logic [2:0] EXT_S = 3'b010;
  localparam logic [2:0] EXT_B = 3'b011;
  localparam logic [2:0] EXT_J = 3'b100;

  // ALU operations
  localparam logic [3:0] ALU_ADD = 4'b0000;
  localparam logic [3:0] ALU_COPY = 4'b0011; // Pass immediate, lui
  localparam logic [3:0] ALU_BREAK = 4'b1110;
  localparam logic [3:0] ALU_NOP = 4'b1111;

  // Operand selects
  localparam logic ASRC_REG = 1'b0;
  localparam logic ASRC_PC = 1'b1;

  localparam logic [1:0] BSRC_REG = 2'b00;
  localparam logic [1:0] BSRC_IMM = 2'b01;
  localparam logic [1:0] BSRC_FOUR = 2'b10; // Link value pc + 4

endpackage

/* design/mux_key.sv */
// Keys must be unique or one-hot; with several matches the highest entry index wins
`timescale 1ns/10ps

module mux_key #(
  parameter int NR_KEY = 2,
  parameter int KEY_LEN = 1,
  parameter type DATA_T = logic [0:0]
) (
  input  logic [KEY_LEN-1:0] i_key,
  input  logic [NR_KEY*(KEY_LEN+$bits(DATA_T))-1:0] i_lut, // {key, data} pairs
  input  DATA_T i_default,
  output DATA_T o_out
);

  localparam int DATA_LEN = $bits(DATA_T);
  localparam int PAIR_LEN = KEY_LEN + DATA_LEN;

  always_comb begin
    o_out = i_default;
    for (int i = 0; i < NR_KEY; i++) begin
      // Key sits above its data in each pair
      if (i_lut[i*PAIR_LEN+DATA_LEN +: KEY_LEN] == i_key) begin
        o_out = DATA_T'(i_lut[i*PAIR_LEN +: DATA_LEN]);
      end
    end
  end

endmodule

/* design/instr_decode.sv */
// Decodes only lui, auipc, jal, jalr, addi, sd and ebreak; anything else gives ALU_NOP and no write
`timescale 1ns/10ps

module instr_decode (
  input  logic [31:0] i_inst,
  output logic [rv_pkg::XLEN-1:0] o_imm,
  output logic [4:0] o_ra,
  output logic [4:0] o_rb,
  output logic [4:0] o_rd,
  output logic o_wen,
  output logic o_alu_asrc,
  output logic [1:0] o_alu_bsrc,
  output logic [3:0] o_alu_op,
  output logic o_pc_jump,
  output logic o_pc_from_reg,
  output logic o_store,
  output logic o_break
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [rv_pkg::XLEN-1:0] imm_i, imm_u, imm_s, imm_b, imm_j;
  logic inst_lui, inst_auipc, inst_jal, inst_jalr, inst_addi, inst_sd, inst_ebreak;
  logic type_i, type_u, type_s, type_j;
  logic [2:0] ext_op;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign o_ra = i_inst[19:15];
  assign o_rb = i_inst[24:20];
  assign o_rd = i_inst[11:7];

  // Sign-extended immediates
  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_j = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  assign inst_lui = (opcode == rv_pkg::OPC_LUI);
  assign inst_auipc = (opcode == rv_pkg::OPC_AUIPC);
  assign inst_jal = (opcode == rv_pkg::OPC_JAL);
  assign inst_jalr = (opcode == rv_pkg::OPC_JALR) && (funct3 == rv_pkg::F3_JALR);
  assign inst_addi = (opcode == rv_pkg::OPC_OPIMM) && (funct3 == rv_pkg::F3_ADDI);
  assign inst_sd = (opcode == rv_pkg::OPC_STORE) && (funct3 == rv_pkg::F3_SD);
  assign inst_ebreak = (opcode == rv_pkg::OPC_SYSTEM) && (funct3 == 3'b000);

  assign type_i = inst_addi | inst_jalr | inst_ebreak;
  assign type_u = inst_lui | inst_auipc;
  assign type_s = inst_sd;
  assign type_j = inst_jal;

  mux_key #(.NR_KEY(4), .KEY_LEN(4), .DATA_T(logic [2:0])) u_mux_fmt (
    .i_key({type_i, type_u, type_s, type_j}),
    .i_lut({
      4'b1000, rv_pkg::EXT_I,
      4'b0100, rv_pkg::EXT_U,
      4'b0010, rv_pkg::EXT_S,
      4'b0001, rv_pkg::EXT_J
    }),
    .i_default(rv_pkg::EXT_I),
    .o_out(ext_op)
  );

  mux_key #(.NR_KEY(5), .KEY_LEN(3), .DATA_T(logic [rv_pkg::XLEN-1:0])) u_mux_imm (
    .i_key(ext_op),
    .i_lut({
      rv_pkg::EXT_I, imm_i,
      rv_pkg::EXT_U, imm_u,
      rv_pkg::EXT_S, imm_s,
      rv_pkg::EXT_B, imm_b, // No branches yet
      rv_pkg::EXT_J, imm_j
    }),
    .i_default('0),
    .o_out(o_imm)
  );

  mux_key #(.NR_KEY(3), .KEY_LEN(3), .DATA_T(logic [3:0])) u_mux_alu (
    .i_key({inst_lui, inst_auipc | inst_jal | inst_jalr | inst_addi | inst_sd, inst_ebreak}),
    .i_lut({
      3'b100, rv_pkg::ALU_COPY,
      3'b010, rv_pkg::ALU_ADD,
      3'b001, rv_pkg::ALU_BREAK
    }),
    .i_default(rv_pkg::ALU_NOP),
    .o_out(o_alu_op)
  );

  assign o_wen = inst_addi | inst_jalr | inst_lui | inst_auipc | inst_jal;
  assign o_alu_asrc = (inst_auipc | inst_jal | inst_jalr) ? rv_pkg::ASRC_PC : rv_pkg::ASRC_REG;
  assign o_alu_bsrc = (inst_jal | inst_jalr) ? rv_pkg::BSRC_FOUR :
                      (inst_addi | inst_lui | inst_auipc | inst_sd) ? rv_pkg::BSRC_IMM :
                      rv_pkg::BSRC_REG;

  assign o_pc_jump = inst_jal | inst_jalr;
  assign o_pc_from_reg = inst_jalr; // Target base is rs1
  assign o_store = inst_sd;
  assign o_break = inst_ebreak;

endmodule

/* design/reg_file.sv */
// Integer register file; x0 is hardwired to zero and reset clears every entry
`timescale 1ns/10ps

module reg_file (
  input  logic i_clk,
  input  logic i_reset,
  input  logic [4:0] i_ra,
  input  logic [4:0] i_rb,
  output logic [rv_pkg::XLEN-1:0] o_rdata_a,
  output logic [rv_pkg::XLEN-1:0] o_rdata_b,
  input  logic i_we,
  input  logic [4:0] i_waddr,
  input  logic [rv_pkg::XLEN-1:0] i_wdata
);

  logic [rv_pkg::XLEN-1:0] regs [rv_pkg::NR_REGS];

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int i = 0; i < rv_pkg::NR_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_waddr != 5'd0) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // Async read
  assign o_rdata_a = (i_ra == 5'd0) ? '0 : regs[i_ra];
  assign o_rdata_b = (i_rb == 5'd0) ? '0 : regs[i_rb];

endmodule

/* design/alu.sv */
// Execute unit for add and copy-immediate only; break and nop results are zero
`timescale 1ns/10ps

module alu (
  input  logic [rv_pkg::XLEN-1:0] i_pc,
  input  logic [rv_pkg::XLEN-1:0] i_rs1,
  input  logic [rv_pkg::XLEN-1:0] i_rs2,
  input  logic [rv_pkg::XLEN-1:0] i_imm,
  input  logic i_asrc,
  input  logic [1:0] i_bsrc,
  input  logic [3:0] i_op,
  output logic [rv_pkg::XLEN-1:0] o_result
);

  logic [rv_pkg::XLEN-1:0] op_a, op_b;

  assign op_a = (i_asrc == rv_pkg::ASRC_PC) ? i_pc : i_rs1;

  always_comb begin
    case (i_bsrc)
      rv_pkg::BSRC_REG:  op_b = i_rs2;
      rv_pkg::BSRC_IMM:  op_b = i_imm;
      rv_pkg::BSRC_FOUR: op_b = 64'd4;
      default:           op_b = '0;
    endcase
  end

  always_comb begin
    case (i_op)
      rv_pkg::ALU_ADD:                    o_result = op_a + op_b;
      rv_pkg::ALU_COPY:                   o_result = i_imm; // lui
      rv_pkg::ALU_BREAK, rv_pkg::ALU_NOP: o_result = '0;
      default:                            o_result = '0;
    endcase
  end

endmodule

/* design/instr_mem.sv */
// Word-addressed instruction store; depth must equal 2**IMEM_AW so that indices wrap
`timescale 1ns/10ps

module instr_mem (
  input  logic i_clk,
  input  logic i_we,
  input  logic [rv_pkg::IMEM_AW-1:0] i_waddr,
  input  logic [31:0] i_wdata,
  input  logic [rv_pkg::IMEM_AW-1:0] i_raddr,
  output logic [31:0] o_rdata
);

  logic [31:0] mem [rv_pkg::IMEM_DEPTH];

  // Load port, used while the core sits in reset
  always_ff @(posedge i_clk) begin
    if (i_we) begin
      mem[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata = mem[i_raddr]; // Comb fetch

endmodule

/* design/core_top.sv */
// Single-cycle RV64 subset core; load imem only during reset, stores are unacknowledged, halts on ebreak
`timescale 1ns/10ps

module core_top (
  input  logic i_clk,
  input  logic i_reset,
  input  logic i_imem_we,
  input  logic [rv_pkg::IMEM_AW-1:0] i_imem_addr,
  input  logic [31:0] i_imem_wdata,
  output logic [rv_pkg::XLEN-1:0] o_pc,
  output logic o_st_valid,
  output logic [rv_pkg::XLEN-1:0] o_st_addr,
  output logic [rv_pkg::XLEN-1:0] o_st_data,
  output logic o_halt
);

  logic [rv_pkg::XLEN-1:0] pc, pc_next, jump_target;
  logic halted;
  logic [31:0] inst;
  logic [rv_pkg::XLEN-1:0] imm, rs1_val, rs2_val, alu_result;
  logic [4:0] ra, rb, rd;
  logic wen, alu_asrc, pc_jump, pc_from_reg, is_store, is_break;
  logic [1:0] alu_bsrc;
  logic [3:0] alu_op;
  logic rf_we;

  instr_mem u_instr_mem (
    .i_clk(i_clk),
    .i_we(i_imem_we),
    .i_waddr(i_imem_addr),
    .i_wdata(i_imem_wdata),
    .i_raddr(pc[rv_pkg::IMEM_AW+1:2]), // Word index
    .o_rdata(inst)
  );

  instr_decode u_instr_decode (
    .i_inst(inst),
    .o_imm(imm),
    .o_ra(ra),
    .o_rb(rb),
    .o_rd(rd),
    .o_wen(wen),
    .o_alu_asrc(alu_asrc),
    .o_alu_bsrc(alu_bsrc),
    .o_alu_op(alu_op),
    .o_pc_jump(pc_jump),
    .o_pc_from_reg(pc_from_reg),
    .o_store(is_store),
    .o_break(is_break)
  );

  assign rf_we = wen & ~halted & ~i_reset;

  reg_file u_reg_file (
    .i_clk(i_clk),
    .i_reset(i_reset),
    .i_ra(ra),
    .i_rb(rb),
    .o_rdata_a(rs1_val),
    .o_rdata_b(rs2_val),
    .i_we(rf_we),
    .i_waddr(rd),
    .i_wdata(alu_result)
  );

  alu u_alu (
    .i_pc(pc),
    .i_rs1(rs1_val),
    .i_rs2(rs2_val),
    .i_imm(imm),
    .i_asrc(alu_asrc),
    .i_bsrc(alu_bsrc),
    .i_op(alu_op),
    .o_result(alu_result)
  );

  // jalr clears bit 0 of its target
  assign jump_target = pc_from_reg ? ((rs1_val + imm) & ~64'd1) : (pc + imm);
  assign pc_next = pc_jump ? jump_target : pc + 64'd4;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      pc <= rv_pkg::RESET_PC;
      halted <= 1'b0;
    end else if (!halted) begin
      if (is_break) begin
        halted <= 1'b1; // PC stays on the ebreak
      end else begin
        pc <= pc_next;
      end
    end
  end

  assign o_pc = pc;
  assign o_halt = halted;
  assign o_st_valid = is_store & ~halted & ~i_reset;
  assign o_st_addr = alu_result; // rs1 + S-imm
  assign o_st_data = rs2_val;

endmodule

/* dv/core_props.sv */
// Bound into core_top; relies on its internal nets ra, rb, rs1_val and rs2_val
`timescale 1ns/10ps

module core_props (
  input logic i_clk,
  input logic i_reset,
  input logic i_st_valid,
  input logic i_halt,
  input logic [rv_pkg::XLEN-1:0] i_pc,
  input logic [4:0] i_ra,
  input logic [4:0] i_rb,
  input logic [rv_pkg::XLEN-1:0] i_rs1,
  input logic [rv_pkg::XLEN-1:0] i_rs2
);

  int n_fail = 0;

  // Halt clears on the first reset edge
  a_reset_quiet: assert property (@(posedge i_clk)
    i_reset && $past(i_reset) |-> !i_st_valid && !i_halt)
    else begin
      $error("Store strobe or halt high during reset");
      n_fail++;
    end

  a_halt_pc: assert property (@(posedge i_clk) i_halt && !i_reset |=> $stable(i_pc))
    else begin
      $error("PC moved while halted");
      n_fail++;
    end

  a_x0_zero: assert property (@(posedge i_clk)
    (i_ra != 5'd0 || i_rs1 == '0) && (i_rb != 5'd0 || i_rs2 == '0))
    else begin
      $error("Register x0 read nonzero");
      n_fail++;
    end

  a_halt_no_store: assert property (@(posedge i_clk) i_halt |-> !i_st_valid)
    else begin
      $error("Store strobe high while halted");
      n_fail++;
    end

endmodule

bind core_top core_props u_core_props (
  .i_clk(i_clk),
  .i_reset(i_reset),
  .i_st_valid(o_st_valid),
  .i_halt(o_halt),
  .i_pc(o_pc),
  .i_ra(ra),
  .i_rb(rb),
  .i_rs1(rs1_val),
  .i_rs2(rs2_val)
);

/* dv/core_tb.sv */
// Programs must end in ebreak within the 256-word imem; words past a program keep stale contents
`timescale 1ns/10ps

module core_tb;

  logic i_clk, i_reset, i_imem_we;
  logic [rv_pkg::IMEM_AW-1:0] i_imem_addr;
  logic [31:0] i_imem_wdata;
  logic [rv_pkg::XLEN-1:0] o_pc, o_st_addr, o_st_data;
  logic o_st_valid, o_halt;

  logic [31:0] prog [rv_pkg::IMEM_DEPTH];
  logic [63:0] exp_addr [$];
  logic [63:0] exp_data [$];
  logic [63:0] exp_pc;
  logic [31:0] rng = 32'hf848_cbf2;
  int prog_len, errors, n_stores;
  time wd_deadline;

  core_top u_core_top (.*);

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s ^= s << 13;
    s ^= s >> 17;
    s ^= s << 5;
    return s;
  endfunction

  // Instruction encoders
  function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], rv_pkg::F3_ADDI, rd[4:0], rv_pkg::OPC_OPIMM};
  endfunction

  function automatic logic [31:0] jalr(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], rv_pkg::F3_JALR, rd[4:0], rv_pkg::OPC_JALR};
  endfunction

  function automatic logic [31:0] lui(input int rd, input int imm);
    return {imm[19:0], rd[4:0], rv_pkg::OPC_LUI};
  endfunction

  function automatic logic [31:0] auipc(input int rd, input int imm);
    return {imm[19:0], rd[4:0], rv_pkg::OPC_AUIPC};
  endfunction

  function automatic logic [31:0] sd(input int rs2, input int base, input int imm);
    return {imm[11:5], rs2[4:0], base[4:0], rv_pkg::F3_SD, imm[4:0], rv_pkg::OPC_STORE};
  endfunction

  function automatic logic [31:0] jal(input int rd, input int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], rv_pkg::OPC_JAL};
  endfunction

  function automatic logic [31:0] ebreak();
    return {12'd1, 5'd0, 3'b000, 5'd0, rv_pkg::OPC_SYSTEM};
  endfunction

  function automatic void emit(input logic [31:0] w);
    prog[prog_len] = w;
    prog_len++;
  endfunction

  // ISA-level model, runs the loaded program up to ebreak
  function automatic void run_model();
    logic [63:0] x [32];
    logic [63:0] pc, next, imm_i, imm_u, imm_s;
    logic [31:0] w;
    logic [4:0] rd, rs1, rs2;
    for (int i = 0; i < 32; i++) x[i] = '0;
    pc = rv_pkg::RESET_PC;
    exp_addr.delete();
    exp_data.delete();
    exp_pc = '1;
    for (int n = 0; n < 1000; n++) begin
      w = prog[pc[rv_pkg::IMEM_AW+1:2]];
      rd = w[11:7];
      rs1 = w[19:15];
      rs2 = w[24:20];
      imm_i = {{52{w[31]}}, w[31:20]};
      imm_u = {{32{w[31]}}, w[31:12], 12'h000};
      imm_s = {{52{w[31]}}, w[31:25], w[11:7]};
      next = pc + 64'd4;
      case (w[6:0])
        rv_pkg::OPC_LUI: x[rd] = imm_u;
        rv_pkg::OPC_AUIPC: x[rd] = pc + imm_u;
        rv_pkg::OPC_JAL: begin
          next = pc + {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
          x[rd] = pc + 64'd4;
        end
        rv_pkg::OPC_JALR: if (w[14:12] == 3'b000) begin
          next = (x[rs1] + imm_i) & ~64'd1; // Target before link, rd may equal rs1
          x[rd] = pc + 64'd4;
        end
        rv_pkg::OPC_OPIMM: if (w[14:12] == 3'b000) x[rd] = x[rs1] + imm_i;
        rv_pkg::OPC_STORE: if (w[14:12] == 3'b011) begin
          exp_addr.push_back(x[rs1] + imm_s);
          exp_data.push_back(x[rs2]);
        end
        rv_pkg::OPC_SYSTEM: if (w[14:12] == 3'b000) begin
          exp_pc = pc;
          return;
        end
        default: ;
      endcase
      x[0] = '0;
      pc = next;
    end
  endfunction

  task automatic check(input string name, input logic [63:0] expected, input logic [63:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("ERR %0t %s expected=%h actual=%h", $time, name, expected, actual);
    end
  endtask

  // Loads the program during reset, then runs it to halt
  task automatic run_program();
    int exp_count;
    int stores_before;
    run_model();
    exp_count = exp_addr.size();
    stores_before = n_stores;
    @(posedge i_clk);
    #1;
    wd_deadline = $time + 64'(20 * (13 + 21 * prog_len));
    i_reset = 1'b1;
    repeat (3) @(posedge i_clk);
    #1;
    for (int i = 0; i < prog_len; i++) begin
      i_imem_we = 1'b1;
      i_imem_addr = rv_pkg::IMEM_AW'(i);
      i_imem_wdata = prog[i];
      @(posedge i_clk);
      #1;
    end
    i_imem_we = 1'b0;
    i_reset = 1'b0;
    @(negedge i_clk);
    while (o_halt !== 1'b1) @(negedge i_clk);
    check("o_pc", exp_pc, o_pc);
    repeat (4) @(negedge i_clk); // Stores after ebreak would land here
    check("store_count", 64'(exp_count), 64'(n_stores - stores_before));
    prog_len = 0;
  endtask

  task automatic build_random();
    for (int n = 0; n < 12; n++) begin
      rng = xorshift(rng);
      case (rng[9:8])
        2'd2: emit(lui(int'(rng[4:2]), int'(rng[31:12])));
        2'd3: emit(sd(int'(rng[7:5]), int'(rng[4:2]), int'(rng[31:20])));
        default: emit(addi(int'(rng[4:2]), int'(rng[7:5]), int'(rng[31:20])));
      endcase
    end
    emit(ebreak());
  endtask

  always @(negedge i_clk) begin
    if (!i_reset && o_st_valid === 1'b1) begin
      n_stores++;
      if (exp_addr.size() == 0) begin
        errors++;
        $display("Unexpected store to address %h at time %0t", o_st_addr, $time);
      end else begin
        check("o_st_addr", exp_addr.pop_front(), o_st_addr);
        check("o_st_data", exp_data.pop_front(), o_st_data);
      end
    end
  end

  always @(posedge i_clk) begin
    if ($time > wd_deadline) begin
      $display("Timeout, the program did not reach ebreak in time");
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    i_reset = 1'b1;
    i_imem_we = 1'b0;
    i_imem_addr = '0;
    i_imem_wdata = '0;
    errors = 0;
    prog_len = 0;
    n_stores = 0;
    wd_deadline = 64'd2000;
    // addi chain, x0 stays zero
    emit(addi(1, 0, -5));
    emit(addi(2, 1, 100));
    emit(addi(3, 2, -2048));
    emit(addi(4, 3, 2047));
    emit(addi(0, 1, 7));
    emit(addi(5, 0, 256));
    emit(sd(1, 5, 0));
    emit(sd(2, 5, 8));
    emit(sd(3, 5, 16));
    emit(sd(4, 5, -8));
    emit(sd(0, 5, 24));
    emit(ebreak());
    run_program();
    // Upper immediates
    emit(lui(1, 32'h80000));
    emit(lui(2, 32'h12345));
    emit(auipc(3, 32'hfffff));
    emit(auipc(4, 32'h00010));
    emit(sd(1, 0, 0));
    emit(sd(2, 0, 8));
    emit(sd(3, 0, 16));
    emit(sd(4, 0, 24));
    emit(ebreak());
    run_program();
    emit(addi(6, 0, 64));
    emit(jal(1, 12)); // Skips two stores
    emit(sd(6, 6, 0));
    emit(sd(6, 6, 8));
    emit(sd(1, 6, 16));
    emit(ebreak());
    run_program();
    emit(addi(5, 0, 512));
    emit(addi(2, 0, 17));
    emit(jalr(3, 2, 4)); // Odd target 21
    emit(sd(5, 5, 0));
    emit(sd(5, 5, 8));
    emit(sd(3, 5, 16));
    emit(sd(2, 5, 24));
    emit(ebreak());
    run_program();
    emit(addi(1, 0, 9));
    emit(sd(1, 0, 0));
    emit(ebreak());
    emit(sd(1, 0, 8));
    emit(sd(1, 0, 16));
    emit(addi(1, 0, 1));
    run_program();
    for (int p = 0; p < 20; p++) begin
      build_random();
      run_program();
    end
    $display("Errors: %0d, assertion failures: %0d", errors, u_core_top.u_core_props.n_fail);
    if (errors == 0 && u_core_top.u_core_props.n_fail == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* project.f */
design/rv_pkg.sv
design/mux_key.sv
design/instr_decode.sv
design/reg_file.sv
design/alu.sv
design/instr_mem.sv
design/core_top.sv
dv/core_props.sv
dv/core_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module core_tb -f project.f -o core_sim
./obj_dir/core_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log
grep -q '^\*\* PASS \*\*$' sim.log
